// File: hdl/batch_counter.sv
/* issue and retire indices of one batch with last-item flags */
`timescale 1ns/1ps
`default_nettype none

module batch_counter (
    input  logic                clk,
    input  logic                reset,
    input  logic                clear,
    input  sqrt_pkg::count_t    count,
    input  logic                issue,
    input  logic                retire,
    output sqrt_pkg::buf_addr_t issue_idx,
    output sqrt_pkg::buf_addr_t retire_idx,
    output logic                issue_last,
    output logic                retire_last
);

    sqrt_pkg::count_t    len_q;                     // batch length
    sqrt_pkg::buf_addr_t issue_q;
    sqrt_pkg::buf_addr_t retire_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            len_q    <= '0;
            issue_q  <= '0;
            retire_q <= '0;
        end else if (clear) begin
            len_q    <= count;                      // new batch
            issue_q  <= '0;
            retire_q <= '0;
        end else begin
            if (issue) begin
                issue_q <= issue_q + 4'd1;
            end
            if (retire) begin
                retire_q <= retire_q + 4'd1;
            end
        end
    end

    // count of 0 never matches, fsm skips that case
    assign issue_last  = ({1'b0, issue_q} == len_q - 5'd1);
    assign retire_last = ({1'b0, retire_q} == len_q - 5'd1);
    assign issue_idx   = issue_q;
    assign retire_idx  = retire_q;

endmodule

`default_nettype wire

// File: hdl/batch_fsm.sv
/* batch FSM: start, issue, drain, done */
`timescale 1ns/1ps
`default_nettype none

module batch_fsm (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  sqrt_pkg::count_t count,
    input  logic             issue_last,
    input  logic             retire,
    input  logic             retire_last,
    output logic             clear,
    output logic             issue_en,
    output logic             busy,
    output logic             done
);

    sqrt_pkg::batch_state_t state_q;
    sqrt_pkg::batch_state_t state_d;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= sqrt_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        clear   = 1'b0;
        case (state_q)
            sqrt_pkg::st_idle, sqrt_pkg::st_done: begin
                if (start) begin
                    clear = 1'b1;                   // counter loads count
                    if (count == '0) begin
                        state_d = sqrt_pkg::st_done;    // empty batch
                    end else begin
                        state_d = sqrt_pkg::st_issue;
                    end
                end
            end
            sqrt_pkg::st_issue: begin
                if (issue_last) begin
                    state_d = sqrt_pkg::st_drain;   // last operand goes out now
                end
            end
            sqrt_pkg::st_drain: begin
                if (retire && retire_last) begin
                    state_d = sqrt_pkg::st_done;
                end
            end
            default: state_d = sqrt_pkg::st_idle;
        endcase
    end

    assign issue_en = (state_q == sqrt_pkg::st_issue);
    assign busy     = (state_q == sqrt_pkg::st_issue) || (state_q == sqrt_pkg::st_drain);
    assign done     = (state_q == sqrt_pkg::st_done);   // held until next start

endmodule

`default_nettype wire

// File: hdl/sample_ram.sv
/* 16-entry Q4.15 buffer, one write port,
   one registered read port with valid flag */
`timescale 1ns/1ps
`default_nettype none
`include "sqrt_params.svh"

module sample_ram (
    input  logic                clk,
    input  logic                reset,
    input  logic                wr_en,
    input  sqrt_pkg::buf_addr_t wr_addr,
    input  sqrt_pkg::fix_t      wr_data,
    input  logic                rd_en,
    input  sqrt_pkg::buf_addr_t rd_addr,
    output sqrt_pkg::sample_t   rd_data
);

    sqrt_pkg::fix_t mem [`SQRT_BUF_DEPTH];
    sqrt_pkg::fix_t rd_q;
    logic           rd_valid_q;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_q <= mem[rd_addr];                   // old data on same-address write
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_en;                    // one cycle behind rd_en
        end
    end

    assign rd_data = {rd_valid_q, rd_q};

endmodule

`default_nettype wire

// File: hdl/segment_select.sv
/* first pipeline stage: breakpoint compare and
   slope/intercept lookup, registered with the operand */
`timescale 1ns/1ps
`default_nettype none
`include "sqrt_params.svh"

module segment_select (
    input  logic              clk,
    input  logic              reset,
    input  sqrt_pkg::sample_t in,
    output sqrt_pkg::sample_t out,
    output sqrt_pkg::coef_t   coef
);

    localparam sqrt_pkg::fix_t bp [8] = '{
        `SQRT_X1, `SQRT_X2, `SQRT_X3, `SQRT_X4,
        `SQRT_X5, `SQRT_X6, `SQRT_X7, `SQRT_X8
    };
    localparam sqrt_pkg::fix_t slope_tab [`SQRT_SEGS] = '{
        `SQRT_M1, `SQRT_M2, `SQRT_M3, `SQRT_M4, `SQRT_M5,
        `SQRT_M6, `SQRT_M7, `SQRT_M8, `SQRT_M9
    };
    localparam sqrt_pkg::fix_t icpt_tab [`SQRT_SEGS] = '{
        `SQRT_C1, `SQRT_C2, `SQRT_C3, `SQRT_C4, `SQRT_C5,
        `SQRT_C6, `SQRT_C7, `SQRT_C8, `SQRT_C9
    };

    sqrt_pkg::fix_t     op;         // operand, sign bit dropped
    sqrt_pkg::seg_idx_t seg;
    logic               valid_q;
    sqrt_pkg::fix_t     data_q;
    sqrt_pkg::coef_t    coef_q;

    assign op = {1'b0, in.data[`SQRT_FIX_W-2:0]};   // negatives unsupported

    // segment = number of breakpoints at or below the operand
    always_comb begin
        seg = '0;
        for (int i = 0; i < 8; i++) begin
            if (op >= bp[i]) begin
                seg = seg + 4'd1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= op;
        coef_q <= {slope_tab[seg], icpt_tab[seg]};  // slope high, intercept low
    end

    assign out  = {valid_q, data_q};
    assign coef = coef_q;

endmodule

`default_nettype wire

// File: hdl/sqrt_accel.sv
/* square-root accelerator top: Wishbone slave, batch FSM and counter,
   operand and result buffers, sqrt pipeline */
`timescale 1ns/1ps
`default_nettype none

module sqrt_accel (
    input  logic              clk,
    input  logic              reset,
    input  sqrt_pkg::wb_req_t wb_req,
    output sqrt_pkg::wb_rsp_t wb_rsp
);

    logic                start;
    sqrt_pkg::count_t    count;
    logic                host_wr_en;
    sqrt_pkg::buf_addr_t host_addr;
    sqrt_pkg::fix_t      host_wr_data;
    logic                host_rd_en;
    logic                clear;
    logic                issue_en;
    logic                busy;
    logic                done;
    sqrt_pkg::buf_addr_t issue_idx;
    sqrt_pkg::buf_addr_t retire_idx;
    logic                issue_last;
    logic                retire_last;
    sqrt_pkg::buf_addr_t opnd_rd_addr;
    logic                opnd_rd_en;
    sqrt_pkg::sample_t   opnd_q;                    // operand buffer read port
    sqrt_pkg::sample_t   pipe_in;
    sqrt_pkg::sample_t   pipe_out;
    sqrt_pkg::sample_t   res_q;                     // result buffer read port

    // FSM owns the operand read port during a batch
    assign opnd_rd_addr = busy ? issue_idx : host_addr;
    assign opnd_rd_en   = busy ? issue_en : host_rd_en;
    assign pipe_in      = {opnd_q.valid && busy, opnd_q.data};  // host reads stay out

    wb_regs wb_regs_i (
        .clk          (clk),
        .reset        (reset),
        .wb_req       (wb_req),
        .busy         (busy),
        .done         (done),
        .opnd_data    (opnd_q.data),
        .res_data     (res_q.data),
        .wb_rsp       (wb_rsp),
        .start        (start),
        .count        (count),
        .host_wr_en   (host_wr_en),
        .host_addr    (host_addr),
        .host_wr_data (host_wr_data),
        .host_rd_en   (host_rd_en)
    );

    batch_fsm batch_fsm_i (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .count       (count),
        .issue_last  (issue_last),
        .retire      (pipe_out.valid),
        .retire_last (retire_last),
        .clear       (clear),
        .issue_en    (issue_en),
        .busy        (busy),
        .done        (done)
    );

    batch_counter batch_counter_i (
        .clk         (clk),
        .reset       (reset),
        .clear       (clear),
        .count       (count),
        .issue       (issue_en),
        .retire      (pipe_out.valid),
        .issue_idx   (issue_idx),
        .retire_idx  (retire_idx),
        .issue_last  (issue_last),
        .retire_last (retire_last)
    );

    sample_ram opnd_ram_i (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (host_wr_en),
        .wr_addr (host_addr),
        .wr_data (host_wr_data),
        .rd_en   (opnd_rd_en),
        .rd_addr (opnd_rd_addr),
        .rd_data (opnd_q)
    );

    sqrt_pipe sqrt_pipe_i (
        .clk   (clk),
        .reset (reset),
        .in    (pipe_in),
        .out   (pipe_out)
    );

    sample_ram res_ram_i (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (pipe_out.valid),                  // results land in issue order
        .wr_addr (retire_idx),
        .wr_data (pipe_out.data),
        .rd_en   (host_rd_en),
        .rd_addr (host_addr),
        .rd_data (res_q)
    );

endmodule

`default_nettype wire

// File: hdl/sqrt_pipe.sv
/* three-stage piecewise-linear square root:
   segment select, truncating multiply, intercept add */
`timescale 1ns/1ps
`default_nettype none
`include "sqrt_params.svh"

module sqrt_pipe (
    input  logic              clk,
    input  logic              reset,
    input  sqrt_pkg::sample_t in,
    output sqrt_pkg::sample_t out
);

    sqrt_pkg::sample_t s1;                          // stage 1 operand
    sqrt_pkg::coef_t   c1;                          // stage 1 coefficients
    logic signed [2*`SQRT_FIX_W-1:0] prod;          // full-width product
    logic              v2;
    logic              v3;
    sqrt_pkg::fix_t    mul2;
    sqrt_pkg::fix_t    icpt2;
    sqrt_pkg::fix_t    sum3;

    segment_select seg_sel_i (
        .clk   (clk),
        .reset (reset),
        .in    (in),
        .out   (s1),
        .coef  (c1)
    );

    assign prod = $signed(s1.data) * $signed(c1.slope);

    // valid bits follow the data, one per stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else begin
            v2 <= s1.valid;
            v3 <= v2;
        end
    end

    always_ff @(posedge clk) begin
        mul2  <= sqrt_pkg::fix_t'(prod >>> `SQRT_FRAC_W);  // back to Q4.15, truncated
        icpt2 <= c1.icpt;                                  // intercept rides along
        sum3  <= mul2 + icpt2;                             // wraps at 20 bits
    end

    assign out = {v3, sum3};

endmodule

`default_nettype wire

// File: hdl/sqrt_pkg.sv
/* value, index and bus typedefs, sample and coefficient structs,
   batch state enum */
`default_nettype none
`include "sqrt_params.svh"

package sqrt_pkg;

    typedef logic [`SQRT_FIX_W-1:0]    fix_t;       // Q4.15
    typedef logic [3:0]                seg_idx_t;   // segment 0..8
    typedef logic [`SQRT_ADDR_W-1:0]   buf_addr_t;
    typedef logic [`SQRT_CNT_W-1:0]    count_t;     // batch length 0..16
    typedef logic [`SQRT_WB_ADR_W-1:0] wb_addr_t;
    typedef logic [`SQRT_WB_DAT_W-1:0] wb_data_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;              // write data
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;              // read data, valid with ack
    } wb_rsp_t;

    typedef struct packed {
        logic valid;
        fix_t data;
    } sample_t;

    typedef struct packed {
        fix_t slope;
        fix_t icpt;
    } coef_t;

    typedef enum logic [1:0] {
        st_idle,
        st_issue,                   // one operand per cycle
        st_drain,                   // wait for pipeline to empty
        st_done
    } batch_state_t;

endpackage

`default_nettype wire

// File: hdl/wb_regs.sv
/* Wishbone classic slave: CTRL, STATUS, operand and result windows */
`timescale 1ns/1ps
`default_nettype none
`include "sqrt_params.svh"

module wb_regs (
    input  logic                clk,
    input  logic                reset,
    input  sqrt_pkg::wb_req_t   wb_req,
    input  logic                busy,
    input  logic                done,
    input  sqrt_pkg::fix_t      opnd_data,
    input  sqrt_pkg::fix_t      res_data,
    output sqrt_pkg::wb_rsp_t   wb_rsp,
    output logic                start,
    output sqrt_pkg::count_t    count,
    output logic                host_wr_en,
    output sqrt_pkg::buf_addr_t host_addr,
    output sqrt_pkg::fix_t      host_wr_data,
    output logic                host_rd_en
);

    localparam logic [1:0] sel_none   = 2'd0;
    localparam logic [1:0] sel_status = 2'd1;
    localparam logic [1:0] sel_opnd   = 2'd2;
    localparam logic [1:0] sel_res    = 2'd3;

    logic             ack_q;
    logic [1:0]       sel_q;                        // read source for the ack cycle
    logic             req;
    logic             is_ctrl;
    logic             is_status;
    logic             is_opnd;
    logic             is_res;
    sqrt_pkg::count_t wr_count;

    assign req       = wb_req.cyc && wb_req.stb && !ack_q;  // no second ack
    assign is_ctrl   = (wb_req.adr == `SQRT_REG_CTRL);
    assign is_status = (wb_req.adr == `SQRT_REG_STATUS);
    assign is_opnd   = ((wb_req.adr & `SQRT_WIN_MASK) == `SQRT_OPND_BASE);
    assign is_res    = ((wb_req.adr & `SQRT_WIN_MASK) == `SQRT_RES_BASE);

    // clamp to buffer depth
    assign wr_count = (wb_req.dat[12:8] > `SQRT_BUF_DEPTH) ? 5'(`SQRT_BUF_DEPTH)
                                                           : wb_req.dat[12:8];

    assign host_addr    = wb_req.adr[`SQRT_ADDR_W-1:0];
    assign host_wr_data = wb_req.dat[`SQRT_FIX_W-1:0];
    assign host_wr_en   = req && wb_req.we && is_opnd && !busy;   // locked during batch
    assign host_rd_en   = req && !wb_req.we && (is_opnd || is_res);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
            sel_q <= sel_none;
            start <= 1'b0;
            count <= '0;
        end else begin
            ack_q <= req;                           // one cycle after sampling
            start <= req && wb_req.we && is_ctrl && wb_req.dat[0] && !busy;
            if (req && wb_req.we && is_ctrl && wb_req.dat[0] && !busy) begin
                count <= wr_count;
            end
            if (req) begin
                if (is_status) begin
                    sel_q <= sel_status;
                end else if (is_opnd) begin
                    sel_q <= sel_opnd;
                end else if (is_res) begin
                    sel_q <= sel_res;
                end else begin
                    sel_q <= sel_none;              // CTRL reads as zero
                end
            end
        end
    end

    // buffer data arrives with ack from the registered read port
    always_comb begin
        wb_rsp.ack = ack_q;
        case (sel_q)
            sel_status: wb_rsp.dat = {30'd0, done, busy};
            sel_opnd:   wb_rsp.dat = {12'd0, opnd_data};
            sel_res:    wb_rsp.dat = {12'd0, res_data};
            default:    wb_rsp.dat = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: include/sqrt_params.svh
/* widths, buffer depth and register map of the square-root accelerator
   breakpoints, slopes and intercepts of the nine-segment Q4.15 approximation */
`ifndef SQRT_PARAMS_SVH
`define SQRT_PARAMS_SVH

`define SQRT_FIX_W      20              // Q4.15 word
`define SQRT_FRAC_W     15
`define SQRT_BUF_DEPTH  16
`define SQRT_ADDR_W     4               // log2 of buffer depth
`define SQRT_CNT_W      5               // holds 0..16
`define SQRT_SEGS       9
`define SQRT_WB_ADR_W   6               // word address
`define SQRT_WB_DAT_W   32

`define SQRT_REG_CTRL   6'h00
`define SQRT_REG_STATUS 6'h01
`define SQRT_OPND_BASE  6'h10
`define SQRT_RES_BASE   6'h20
`define SQRT_WIN_MASK   6'h30           // selects a buffer window

`define SQRT_X1 20'h00AA7               // ~0.0833
`define SQRT_X2 20'h0243E               // ~0.2832
`define SQRT_X3 20'h0531D               // ~0.6493
`define SQRT_X4 20'h09B84               // ~1.2150
`define SQRT_X5 20'h0FCCF               // ~1.9751
`define SQRT_X6 20'h187B8               // ~3.0603
`define SQRT_X7 20'h23B77               // ~4.4646
`define SQRT_X8 20'h30B75               // ~6.0895

`define SQRT_M1 20'h1BB9F               // ~3.4658
`define SQRT_M2 20'h09BF8
`define SQRT_M3 20'h05FAB
`define SQRT_M4 20'h04315
`define SQRT_M5 20'h0330B
`define SQRT_M6 20'h02892
`define SQRT_M7 20'h02123
`define SQRT_M8 20'h01BF1
`define SQRT_M9 20'h0182B               // ~0.1888

`define SQRT_C1 20'h00000               // first segment passes through origin
`define SQRT_C2 20'h017F2
`define SQRT_C3 20'h02905
`define SQRT_C4 20'h03B95
`define SQRT_C5 20'h04F12
`define SQRT_C6 20'h063C0
`define SQRT_C7 20'h07A7F
`define SQRT_C8 20'h091B3
`define SQRT_C9 20'h0A8B0               // ~1.3179

`endif

// File: run.sh
#!/usr/bin/env bash
# Build the square-root accelerator testbench with Verilator and run it.
# The run counts as passed only if the pass line shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module sqrt_accel_tb -f sim.f \
    && ./obj_dir/Vsqrt_accel_tb 2>&1 | tee /dev/stderr | grep -q "All tests passed" \
    && echo "simulation run: PASS" \
    || { echo "simulation run: FAIL"; exit 1; }

// File: sim.f
+incdir+include
hdl/sqrt_pkg.sv
hdl/segment_select.sv
hdl/sqrt_pipe.sv
hdl/sample_ram.sv
hdl/batch_counter.sv
hdl/batch_fsm.sv
hdl/wb_regs.sv
hdl/sqrt_accel.sv
test/sqrt_accel_assert.sv
test/sqrt_accel_tb.sv

// File: test/sqrt_accel_assert.sv
/* concurrent checks bound into the accelerator top:
   single-cycle ack, busy/done exclusion, pipeline latency */
`timescale 1ns/1ps
`default_nettype none

module sqrt_accel_assert (
    input logic clk,
    input logic reset,
    input logic ack,
    input logic busy,
    input logic done,
    input logic pipe_in_valid,
    input logic pipe_out_valid
);

    // classic slave acks once per request
    ack_one_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else $error("Wishbone ack stayed high for more than one cycle");

    busy_done_excl: assert property (@(posedge clk) disable iff (reset) !(busy && done))
        else $error("busy and done high together");

    // three register stages between pipe input and output
    pipe_latency: assert property (@(posedge clk) disable iff (reset)
        pipe_out_valid == $past(pipe_in_valid, 3))
        else $error("pipeline output valid not three cycles after input valid");

endmodule

bind sqrt_accel sqrt_accel_assert sqrt_accel_assert_i (
    .clk            (clk),
    .reset          (reset),
    .ack            (wb_rsp.ack),
    .busy           (busy),
    .done           (done),
    .pipe_in_valid  (pipe_in.valid),
    .pipe_out_valid (pipe_out.valid)
);

`default_nettype wire

// File: test/sqrt_accel_tb.sv
/* testbench for the square-root accelerator: clock, reset, Wishbone bus tasks,
   reference model, compare tasks, directed and seeded random batches, watchdog */
`timescale 1ns/1ps
`default_nettype none
`include "sqrt_params.svh"

module sqrt_accel_tb;

    localparam int n_batches = 36;                  // 2 + 30 + 2 + 2
    localparam sqrt_pkg::fix_t bp_tab [8] = '{
        `SQRT_X1, `SQRT_X2, `SQRT_X3, `SQRT_X4,
        `SQRT_X5, `SQRT_X6, `SQRT_X7, `SQRT_X8
    };
    localparam sqrt_pkg::fix_t m_tab [9] = '{
        `SQRT_M1, `SQRT_M2, `SQRT_M3, `SQRT_M4, `SQRT_M5,
        `SQRT_M6, `SQRT_M7, `SQRT_M8, `SQRT_M9
    };
    localparam sqrt_pkg::fix_t c_tab [9] = '{
        `SQRT_C1, `SQRT_C2, `SQRT_C3, `SQRT_C4, `SQRT_C5,
        `SQRT_C6, `SQRT_C7, `SQRT_C8, `SQRT_C9
    };

    logic              clk;
    logic              reset;
    sqrt_pkg::wb_req_t wb_req;
    sqrt_pkg::wb_rsp_t wb_rsp;
    sqrt_pkg::fix_t    ops [`SQRT_BUF_DEPTH];       // operands of the current batch
    sqrt_pkg::wb_data_t rd;

    sqrt_accel sqrt_accel_i (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #5 clk = ~clk;

    // segment count, truncating multiply, wrapping add
    function automatic sqrt_pkg::fix_t sqrt_model(input sqrt_pkg::fix_t x);
        sqrt_pkg::fix_t     op;
        int                 seg;
        logic signed [39:0] prod;
        op = x & 20'h7FFFF;                         // sign bit ignored
        seg = 0;
        for (int i = 0; i < 8; i++) begin
            if (op >= bp_tab[i]) begin
                seg++;
            end
        end
        prod = $signed(op) * $signed(m_tab[seg]);
        return prod[`SQRT_FRAC_W+`SQRT_FIX_W-1:`SQRT_FRAC_W] + c_tab[seg];
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_fix(input string name, input sqrt_pkg::fix_t got,
                             input sqrt_pkg::fix_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR %s got 0x%05h expected 0x%05h", name, got, exp));
        end
    endtask

    task automatic check_status(input string name, input sqrt_pkg::wb_data_t got,
                                input sqrt_pkg::wb_data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    // classic cycle, request held until ack seen
    task automatic wb_write(input sqrt_pkg::wb_addr_t adr, input sqrt_pkg::wb_data_t dat);
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do @(negedge clk); while (!wb_rsp.ack);
        wb_req = '0;                                // drop stb after ack
    endtask

    task automatic wb_read(input sqrt_pkg::wb_addr_t adr, output sqrt_pkg::wb_data_t dat);
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        wb_req.dat = '0;
        do @(negedge clk); while (!wb_rsp.ack);
        dat = wb_rsp.dat;                           // valid while ack high
        wb_req = '0;
    endtask

    task automatic load_operands(input int n);
        for (int i = 0; i < n; i++) begin
            wb_write(`SQRT_OPND_BASE + 6'(i), {12'd0, ops[i]});
        end
    endtask

    task automatic start_batch(input int n);
        wb_write(`SQRT_REG_CTRL, {19'd0, 5'(n), 7'd0, 1'b1});   // count in 12:8
    endtask

    // poll until done, then done must be the only bit
    task automatic wait_done();
        sqrt_pkg::wb_data_t st;
        do wb_read(`SQRT_REG_STATUS, st); while (!st[1]);
        check_status("status after batch", st, 32'd2);
    endtask

    task automatic check_results(input int n);
        sqrt_pkg::wb_data_t res;
        for (int i = 0; i < n; i++) begin
            wb_read(`SQRT_RES_BASE + 6'(i), res);
            check_fix($sformatf("result[%0d]", i), res[`SQRT_FIX_W-1:0], sqrt_model(ops[i]));
        end
    endtask

    task automatic random_operands();
        for (int i = 0; i < `SQRT_BUF_DEPTH; i++) begin
            ops[i] = {1'b0, 19'($urandom)};         // bit 19 clear
        end
    endtask

    initial begin
        repeat (n_batches * 200 + 1000) @(posedge clk);
        fail_run("watchdog timeout: the run did not finish in time");
    end

    initial begin
        clk    = 1'b0;
        reset  = 1'b1;
        wb_req = '0;
        void'($urandom(32'h1a2a_bf0d));
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // idle bus, nothing acked
        repeat (5) begin
            @(negedge clk);
            if (wb_rsp.ack) begin
                fail_run("ack appeared without a request");
            end
        end
        wb_read(`SQRT_REG_STATUS, rd);
        check_status("status after reset", rd, 32'd0);

        // empty batch from idle goes straight to done
        start_batch(0);
        wait_done();

        // single operand batch
        ops[0] = {1'b0, 19'($urandom)};
        load_operands(1);
        start_batch(1);
        wait_done();
        check_results(1);

        // operand buffer readback
        random_operands();
        load_operands(`SQRT_BUF_DEPTH);
        for (int i = 0; i < `SQRT_BUF_DEPTH; i++) begin
            wb_read(`SQRT_OPND_BASE + 6'(i), rd);
            check_fix($sformatf("operand[%0d]", i), rd[`SQRT_FIX_W-1:0], ops[i]);
        end

        for (int b = 0; b < 30; b++) begin
            random_operands();
            load_operands(`SQRT_BUF_DEPTH);
            start_batch(`SQRT_BUF_DEPTH);
            wait_done();
            check_results(`SQRT_BUF_DEPTH);
        end

        // breakpoints and one LSB below
        for (int i = 0; i < 8; i++) begin
            ops[i]     = bp_tab[i];
            ops[8 + i] = bp_tab[i] - 20'd1;
        end
        load_operands(`SQRT_BUF_DEPTH);
        start_batch(`SQRT_BUF_DEPTH);
        wait_done();
        check_results(`SQRT_BUF_DEPTH);
        ops[0] = 20'h00000;
        ops[1] = 20'h7FFFF;                         // largest positive
        load_operands(2);
        start_batch(2);
        wait_done();
        check_results(2);
        wb_read(`SQRT_RES_BASE, rd);
        check_fix("zero operand result", rd[`SQRT_FIX_W-1:0], 20'h00000);

        // start and operand write while busy are both ignored
        random_operands();
        load_operands(`SQRT_BUF_DEPTH);
        start_batch(`SQRT_BUF_DEPTH);
        start_batch(3);
        wb_read(`SQRT_REG_STATUS, rd);
        check_status("status while busy", rd, 32'd1);
        wb_write(`SQRT_OPND_BASE + 6'd5, {12'd0, ~ops[5] & 20'h7FFFF});
        wait_done();
        check_results(`SQRT_BUF_DEPTH);
        wb_read(`SQRT_OPND_BASE + 6'd5, rd);
        check_fix("operand[5] after busy write", rd[`SQRT_FIX_W-1:0], ops[5]);

        // empty batch leaves results alone, new operands must not run
        for (int i = 0; i < `SQRT_BUF_DEPTH; i++) begin
            wb_write(`SQRT_OPND_BASE + 6'(i), {12'd0, ~ops[i] & 20'h7FFFF});
        end
        start_batch(0);
        wait_done();
        check_results(`SQRT_BUF_DEPTH);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
